// File: include/core_params.svh
// Shared constants for the console shell: bridge register map, reset and
// fast-forward timing, sync shaping and the palette reset value.
// Include from any module that needs them. The include path points at include/.

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// bridge register map
`define CFG_ADDR_RESET      32'h0000_0050
`define CFG_ADDR_FF_SND     32'h0000_020C
`define CFG_ADDR_PALETTE    32'h0000_0300

// core reset hold after a reset-address write, in clk_sys cycles
`define RESET_DELAY_CYCLES  64

// fast-forward button
`define FF_TAP_CYCLES       40
`define FF_KEY_BIT          8

// hs delay load, keeps hs pulses clear of vs
`define HS_DELAY_CYCLES     7

`define PALETTE_DEFAULT     128'h8282_1451_7356_305A_5F1A_3B49_0000_0000

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_gb_shell -o sim_tb \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx ">>> PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/av_output_stage.sv
// Audio and video output registers toward the scaler.
// Mutes audio under fast-forward, builds data enable and blanked colour, and
// turns sync edges into single-cycle pulses with hs delayed past vs.

`timescale 1ns/100ps

`include "core_params.svh"

module av_output_stage (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     fast_forward,
    input  logic                     ff_snd_en,
    input  core_av_pkg::audio_pair_t audio_in,
    input  core_av_pkg::video_in_t   video_in,
    output core_av_pkg::audio_pair_t audio_out,
    output core_av_pkg::video_out_t  video_out
);

    import core_av_pkg::*;

    localparam int HS_W = $clog2(`HS_DELAY_CYCLES + 1);

    audio_pair_t     audio_muted;
    logic            de;
    rgb_t            rgb_gated;
    logic            hs_prev;
    logic            vs_prev;
    logic [HS_W-1:0] hs_delay;

    // silent while fast-forwarding unless the host asked for sound
    assign audio_muted = (fast_forward && !ff_snd_en) ? '0 : audio_in;

    assign de        = !(video_in.hblank || video_in.vblank);
    assign rgb_gated = de ? video_in.rgb : '0;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            audio_out <= '0;
            video_out <= '0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
            hs_delay  <= '0;
        end else begin
            audio_out     <= audio_muted;
            video_out.de  <= de;
            video_out.rgb <= rgb_gated;

            // vs pulse straight off the rising edge
            video_out.vs <= video_in.vs && !vs_prev;

            // hs waits out the delay so it never lands on vs
            video_out.hs <= (hs_delay == HS_W'(1));
            if (video_in.hs && !hs_prev) begin
                hs_delay <= HS_W'(`HS_DELAY_CYCLES);
            end else if (hs_delay != '0) begin
                hs_delay <= hs_delay - 1'b1;
            end

            hs_prev <= video_in.hs;
            vs_prev <= video_in.vs;
        end
    end

endmodule

// File: src/core_av_pkg.sv
// Audio, video and palette types of the output path.
// Imported by the output stage and the palette store.

package core_av_pkg;

    typedef logic [23:0] rgb_t;
    typedef logic [15:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } audio_pair_t;

    // raw video from the emulated system
    typedef struct packed {
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
        rgb_t rgb;
    } video_in_t;

    // shaped video toward the scaler
    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
        rgb_t rgb;
    } video_out_t;

    // four shades, pal1 is the lightest
    typedef struct packed {
        rgb_t pal1;
        rgb_t pal2;
        rgb_t pal3;
        rgb_t pal4;
    } palette_t;

endpackage

// File: src/core_cfg_pkg.sv
// Types for the host bridge and the fast-forward controls.
// Imported by the config register bank and the fast-forward blocks.

package core_cfg_pkg;

    // host bridge
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // controller key bitmap, bit 8 is the left shoulder
    typedef logic [31:0] key_word_t;

    // button hold length in clk_sys cycles
    typedef logic [23:0] hold_count_t;

    // fast-forward latch states
    typedef enum logic [1:0] {
        FF_OFF               = 2'd0,
        FF_TAP_FROM_OFF      = 2'd1,
        FF_LATCHED           = 2'd2,
        FF_HOLD_FROM_LATCHED = 2'd3
    } ff_state_t;

endpackage

// File: src/core_config_regs.sv
// Register bank behind the host bridge.
// Decodes bridge writes into the fast-forward sound enable, the palette
// write strobe and the reset countdown that holds the core in reset.

`timescale 1ns/100ps

`include "core_params.svh"

module core_config_regs (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      bridge_wr,
    input  core_cfg_pkg::bridge_addr_t bridge_addr,
    input  core_cfg_pkg::bridge_data_t bridge_wr_data,
    input  logic                      download_active,
    output logic                      ff_snd_en,
    output logic                      palette_wr,
    output logic [15:0]               palette_word,
    output logic                      core_reset
);

    import core_cfg_pkg::*;

    localparam int RST_W = $clog2(`RESET_DELAY_CYCLES + 1);

    logic             wr_reset;
    logic             wr_ff_snd;
    logic [RST_W-1:0] rst_count;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    assign wr_reset   = bridge_wr && (bridge_addr == bridge_addr_t'(`CFG_ADDR_RESET));
    assign wr_ff_snd  = bridge_wr && (bridge_addr == bridge_addr_t'(`CFG_ADDR_FF_SND));
    assign palette_wr = bridge_wr && (bridge_addr == bridge_addr_t'(`CFG_ADDR_PALETTE));

    // palette takes the low half of the bridge word
    assign palette_word = bridge_wr_data[15:0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ff_snd_en <= 1'b0;
        end else if (wr_ff_snd) begin
            ff_snd_en <= bridge_wr_data[0];
        end
    end

    //////////////////////////////////////////////////
    // reset countdown
    //////////////////////////////////////////////////

    // a new write restarts the count from the top
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rst_count <= '0;
        end else if (wr_reset) begin
            rst_count <= RST_W'(`RESET_DELAY_CYCLES);
        end else if (rst_count != '0) begin
            rst_count <= rst_count - 1'b1;
        end
    end

    // a download also keeps the core quiet
    assign core_reset = (rst_count != '0) || download_active;

endmodule

// File: src/ff_hold_timer.sv
// Measures how long the masked fast-forward button stays down.
// short_hold is high while the hold so far is shorter than a tap.

`timescale 1ns/100ps

`include "core_params.svh"

module ff_hold_timer (
    input  logic clk_sys,
    input  logic reset,
    input  logic ff_key,
    output logic short_hold
);

    import core_cfg_pkg::*;

    localparam hold_count_t HOLD_MAX = '1;

    logic        key_prev;
    hold_count_t hold_count;

    // restart on the press edge, then count up and stick at the top
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            key_prev   <= 1'b0;
            hold_count <= '0;
        end else begin
            key_prev <= ff_key;
            if (ff_key && !key_prev) begin
                hold_count <= '0;
            end else if (ff_key && (hold_count != HOLD_MAX)) begin
                hold_count <= hold_count + 1'b1;
            end
        end
    end

    assign short_hold = (hold_count < hold_count_t'(`FF_TAP_CYCLES));

endmodule

// File: src/ff_latch_fsm.sv
// Fast-forward control. A tap latches fast-forward, the next press clears it,
// and a long hold only runs while the button is down. Nothing runs while a
// download is active.

`timescale 1ns/100ps

`include "core_params.svh"

module ff_latch_fsm (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  core_cfg_pkg::key_word_t key_word,
    input  logic                   download_active,
    input  logic                   short_hold,
    output logic                   ff_key,
    output logic                   fast_forward
);

    import core_cfg_pkg::*;

    ff_state_t state_q;
    ff_state_t state_d;

    // shoulder button, ignored during downloads
    assign ff_key = key_word[`FF_KEY_BIT] && !download_active;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FF_OFF: begin
                if (ff_key) begin
                    state_d = FF_TAP_FROM_OFF;
                end
            end
            FF_TAP_FROM_OFF: begin
                // released early enough counts as a tap
                if (!ff_key) begin
                    state_d = short_hold ? FF_LATCHED : FF_OFF;
                end
            end
            FF_LATCHED: begin
                if (ff_key) begin
                    state_d = FF_HOLD_FROM_LATCHED;
                end
            end
            FF_HOLD_FROM_LATCHED: begin
                if (!ff_key) begin
                    state_d = FF_OFF;
                end
            end
            default: state_d = FF_OFF;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_q      <= FF_OFF;
            fast_forward <= 1'b0;
        end else begin
            state_q      <= state_d;
            fast_forward <= ff_key || ((state_q == FF_LATCHED) && !download_active);
        end
    end

endmodule

// File: src/gb_shell_top.sv
// Top of the console shell logic around the emulated system.
// Connects the bridge register bank, fast-forward control, palette store
// and the audio/video output stage.

`timescale 1ns/100ps

module gb_shell_top (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      bridge_wr,
    input  core_cfg_pkg::bridge_addr_t bridge_addr,
    input  core_cfg_pkg::bridge_data_t bridge_wr_data,
    input  logic                      download_active,
    input  core_cfg_pkg::key_word_t    key_word,
    input  core_av_pkg::audio_pair_t   audio_in,
    input  core_av_pkg::video_in_t     video_in,
    output core_av_pkg::audio_pair_t   audio_out,
    output core_av_pkg::video_out_t    video_out,
    output core_av_pkg::palette_t      palette,
    output logic                      core_reset,
    output logic                      fast_forward
);

    logic        ff_snd_en;
    logic        palette_wr;
    logic [15:0] palette_word;
    logic        ff_key;
    logic        short_hold;

    core_config_regs u_config_regs (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .bridge_wr       (bridge_wr),
        .bridge_addr     (bridge_addr),
        .bridge_wr_data  (bridge_wr_data),
        .download_active (download_active),
        .ff_snd_en       (ff_snd_en),
        .palette_wr      (palette_wr),
        .palette_word    (palette_word),
        .core_reset      (core_reset)
    );

    ff_hold_timer u_ff_hold_timer (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .ff_key     (ff_key),
        .short_hold (short_hold)
    );

    ff_latch_fsm u_ff_latch_fsm (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .key_word        (key_word),
        .download_active (download_active),
        .short_hold      (short_hold),
        .ff_key          (ff_key),
        .fast_forward    (fast_forward)
    );

    palette_store u_palette_store (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .palette_wr   (palette_wr),
        .palette_word (palette_word),
        .palette      (palette)
    );

    av_output_stage u_av_output_stage (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .fast_forward (fast_forward),
        .ff_snd_en    (ff_snd_en),
        .audio_in     (audio_in),
        .video_in     (video_in),
        .audio_out    (audio_out),
        .video_out    (video_out)
    );

endmodule

// File: src/palette_store.sv
// DMG palette register. Bridge palette writes shift 16-bit words in, bytes
// swapped, and the top 96 bits drive the four shades.

`timescale 1ns/100ps

`include "core_params.svh"

module palette_store (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  palette_wr,
    input  logic [15:0]           palette_word,
    output core_av_pkg::palette_t palette
);

    import core_av_pkg::*;

    logic [127:0] pal_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pal_q <= `PALETTE_DEFAULT;
        end else if (palette_wr) begin
            // host sends big-endian words
            pal_q <= {pal_q[111:0], palette_word[7:0], palette_word[15:8]};
        end
    end

    // low 32 bits only fill the shift chain
    assign palette = palette_t'(pal_q[127:32]);

endmodule

// File: tb.f
+incdir+include
src/core_cfg_pkg.sv
src/core_av_pkg.sv
src/core_config_regs.sv
src/ff_hold_timer.sv
src/ff_latch_fsm.sv
src/palette_store.sv
src/av_output_stage.sv
src/gb_shell_top.sv
verif/gb_shell_assertions.sv
verif/tb_gb_shell.sv

// File: verif/gb_shell_assertions.sv
// Concurrent checks on the shell outputs, bound into the output stage and
// the fast-forward FSM. Ports that a binding does not use are tied low.

`timescale 1ns/100ps

module gb_shell_assertions (
    input logic clk_sys,
    input logic reset,
    input logic vs_pulse,
    input logic hs_pulse,
    input logic download_active,
    input logic fast_forward
);

    // sync outputs are single-cycle pulses
    vs_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
        vs_pulse |=> !vs_pulse)
        else $error("vs output stayed high for two cycles");

    hs_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
        hs_pulse |=> !hs_pulse)
        else $error("hs output stayed high for two cycles");

    // a download masks fast-forward right away
    ff_masked_by_download: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(download_active) |=> !fast_forward)
        else $error("fast_forward still high after download_active rose");

endmodule

bind av_output_stage gb_shell_assertions u_av_checks (
    .clk_sys         (clk_sys),
    .reset           (reset),
    .vs_pulse        (video_out.vs),
    .hs_pulse        (video_out.hs),
    .download_active (1'b0),
    .fast_forward    (1'b0)
);

bind ff_latch_fsm gb_shell_assertions u_ff_checks (
    .clk_sys         (clk_sys),
    .reset           (reset),
    .vs_pulse        (1'b0),
    .hs_pulse        (1'b0),
    .download_active (download_active),
    .fast_forward    (fast_forward)
);

// File: verif/gb_shell_input.txt
# columns: command a b expected, all hex. R reset write (exp = core_reset cycles),
# P palette word, S sound enable, D download (exp = core_reset), B hold a cycles
# (b = fast_forward held, exp = after release), A a samples (exp = fast_forward),
# V blank bits hblank:vblank and rgb (exp = de), Y/H sync edge (exp = cycles to pulse)
R 0 0 40
D 1 0 1
D 0 0 0
P 1234 0 0
P abcd 0 0
P 00ff 0 0
P 8001 0 0
B a 1 1
A 8 0 1
S 1 0 0
A 8 0 1
D 1 0 1
D 0 0 0
B a 1 0
A 8 0 0
B 3c 1 0
D 1 0 1
B a 0 0
D 0 0 0
S 0 0 0
A 4 0 0
V 0 123456 1
V 2 abcdef 0
V 1 654321 0
V 3 ffffff 0
V 0 00c0de 1
Y 0 0 1
H 0 0 8
Y 0 0 1

// File: verif/tb_gb_shell.sv
// Testbench for gb_shell_top. Reads commands and expected values from the
// input file under verif/, drives the DUT on the falling edge and checks the
// reset countdown, fast-forward, palette, audio and video paths.

`timescale 1ns/100ps

`include "core_params.svh"

module tb_gb_shell;

    import core_cfg_pkg::*;
    import core_av_pkg::*;

    logic         clk_sys = 1'b0;
    logic         reset;
    logic         bridge_wr;
    bridge_addr_t bridge_addr;
    bridge_data_t bridge_wr_data;
    logic         download_active;
    key_word_t    key_word;
    audio_pair_t  audio_in;
    video_in_t    video_in;
    audio_pair_t  audio_out;
    video_out_t   video_out;
    palette_t     palette;
    logic         core_reset;
    logic         fast_forward;

    // command table from the input file
    byte          cmd_q[$];
    logic [31:0]  arg_a_q[$];
    logic [31:0]  arg_b_q[$];
    logic [31:0]  exp_q[$];

    integer       seed = 54134;
    int unsigned  budget_cycles = 0;
    logic         loaded = 1'b0;

    // reference state
    logic [127:0] pal_model = `PALETTE_DEFAULT;
    logic         snd_model = 1'b0;

    gb_shell_top dut0 (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .bridge_wr       (bridge_wr),
        .bridge_addr     (bridge_addr),
        .bridge_wr_data  (bridge_wr_data),
        .download_active (download_active),
        .key_word        (key_word),
        .audio_in        (audio_in),
        .video_in        (video_in),
        .audio_out       (audio_out),
        .video_out       (video_out),
        .palette         (palette),
        .core_reset      (core_reset),
        .fast_forward    (fast_forward)
    );

    always #4 clk_sys = ~clk_sys;

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("Error at time %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // rough cycle cost of one command for the watchdog budget
    function automatic int unsigned cycles_for(byte c, logic [31:0] a, logic [31:0] e);
        case (c)
            "R":      return e + 32'd4;
            "B":      return a + 32'd4;
            "A":      return a + 32'd2;
            "Y", "H": return e + 32'd3;
            default:  return 32'd3;
        endcase
    endfunction

    task automatic load_commands();
        int          fd;
        int          n;
        string       line;
        byte         c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        fd = $fopen("verif/gb_shell_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/gb_shell_input.txt");
            $display(">>> FAIL");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h", c, a, b, e);
            if (n != 4) begin
                $display("malformed line in stimulus file: %s", line);
                $display(">>> FAIL");
                $fatal(1, "bad stimulus line");
            end
            cmd_q.push_back(c);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            exp_q.push_back(e);
            budget_cycles += cycles_for(c, a, e);
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // bridge and control commands
    //////////////////////////////////////////////////

    task automatic write_bridge(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_sys);
        bridge_wr = 1'b0;
    endtask

    task automatic reset_write(input logic [31:0] length_exp);
        int cnt;
        cnt = 0;
        check_value("core_reset", 128'(core_reset), 128'd0);
        write_bridge(`CFG_ADDR_RESET, 32'd0);
        while (core_reset && cnt < 4096) begin
            cnt++;
            @(negedge clk_sys);
        end
        check_value("core_reset length", 128'(cnt), 128'(length_exp));
    endtask

    task automatic palette_write(input logic [15:0] word);
        write_bridge(`CFG_ADDR_PALETTE, {16'd0, word});
        // shift in with bytes swapped
        pal_model = {pal_model[111:0], word[7:0], word[15:8]};
        check_value("palette", 128'(palette), {32'd0, pal_model[127:32]});
    endtask

    task automatic sound_write(input logic [31:0] data);
        write_bridge(`CFG_ADDR_FF_SND, data);
        snd_model = data[0];
    endtask

    task automatic set_download(input logic level, input logic core_reset_exp);
        download_active = level;
        #2;
        check_value("core_reset", 128'(core_reset), 128'(core_reset_exp));
        @(negedge clk_sys);
    endtask

    task automatic hold_button(input int cycles, input logic held_exp,
                               input logic after_exp);
        key_word[`FF_KEY_BIT] = 1'b1;
        repeat (cycles) begin
            @(negedge clk_sys);
            check_value("fast_forward", 128'(fast_forward), 128'(held_exp));
        end
        key_word[`FF_KEY_BIT] = 1'b0;
        // the FSM settles two cycles after release
        repeat (2) @(negedge clk_sys);
        check_value("fast_forward", 128'(fast_forward), 128'(after_exp));
    endtask

    //////////////////////////////////////////////////
    // audio and video commands
    //////////////////////////////////////////////////

    task automatic play_audio(input int count, input logic ff_exp);
        logic [31:0] sample;
        logic [31:0] audio_exp;
        repeat (count) begin
            sample   = $random(seed);
            audio_in = sample;
            @(negedge clk_sys);
            check_value("fast_forward", 128'(fast_forward), 128'(ff_exp));
            audio_exp = (ff_exp && !snd_model) ? 32'd0 : sample;
            check_value("audio_out", 128'(audio_out), 128'(audio_exp));
        end
    endtask

    task automatic show_video(input logic [1:0] blank, input rgb_t rgb, input logic de_exp);
        video_in.hblank = blank[1];
        video_in.vblank = blank[0];
        video_in.rgb    = rgb;
        @(negedge clk_sys);
        check_value("video_out.de", 128'(video_out.de), 128'(de_exp));
        check_value("video_out.rgb", 128'(video_out.rgb), de_exp ? 128'(rgb) : 128'd0);
    endtask

    task automatic sync_edge(input logic is_hs, input logic [31:0] delay_exp);
        int   cnt;
        logic pulse;
        cnt = 0;
        if (is_hs) begin
            video_in.hs = 1'b1;
        end else begin
            video_in.vs = 1'b1;
        end
        do begin
            @(negedge clk_sys);
            cnt++;
            pulse = is_hs ? video_out.hs : video_out.vs;
        end while (!pulse && cnt < 32);
        check_value(is_hs ? "video_out.hs delay" : "video_out.vs delay",
                    128'(cnt), 128'(delay_exp));
        @(negedge clk_sys);
        pulse = is_hs ? video_out.hs : video_out.vs;
        check_value(is_hs ? "video_out.hs" : "video_out.vs", 128'(pulse), 128'd0);
        video_in.hs = 1'b0;
        video_in.vs = 1'b0;
        // let the edge detector see the low level
        @(negedge clk_sys);
    endtask

    task automatic run_command(input byte c, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] e);
        case (c)
            "R": reset_write(e);
            "P": palette_write(a[15:0]);
            "S": sound_write(a);
            "D": set_download(a[0], e[0]);
            "B": hold_button(int'(a), b[0], e[0]);
            "A": play_audio(int'(a), e[0]);
            "V": show_video(a[1:0], b[23:0], e[0]);
            "Y": sync_edge(1'b0, e);
            "H": sync_edge(1'b1, e);
            default: begin
                $display("unknown command letter %c in stimulus file", c);
                $display(">>> FAIL");
                $fatal(1, "bad command");
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin : stimulus
        int i;
        reset           = 1'b1;
        bridge_wr       = 1'b0;
        bridge_addr     = '0;
        bridge_wr_data  = '0;
        download_active = 1'b0;
        key_word        = '0;
        audio_in        = '0;
        video_in        = '0;
        load_commands();
        // reset cycles plus margin
        budget_cycles += 200;
        loaded = 1'b1;
        repeat (5) @(negedge clk_sys);
        check_value("core_reset", 128'(core_reset), 128'd0);
        check_value("fast_forward", 128'(fast_forward), 128'd0);
        check_value("palette", 128'(palette), {32'd0, pal_model[127:32]});
        check_value("audio_out", 128'(audio_out), 128'd0);
        check_value("video_out", 128'(video_out), 128'd0);
        reset = 1'b0;
        for (i = 0; i < cmd_q.size(); i++) begin
            run_command(cmd_q[i], arg_a_q[i], arg_b_q[i], exp_q[i]);
        end
        @(negedge clk_sys);
        $display(">>> PASS");
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (budget_cycles) @(posedge clk_sys);
        $display("timeout: the run did not finish within %0d cycles", budget_cycles);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
